//--- Bender.yml
package:
  name: vga_master

sources:
  - rtl/vga_pkg.sv
  - rtl/vga_timing.sv
  - rtl/vga_palette.sv
  - rtl/vga_line_buffer.sv
  - rtl/vga_fetch.sv
  - rtl/vga_master.sv
  - target: test
    files:
      - testbench/vga_master_checker.sv
      - testbench/vga_master_tb.sv

//--- rtl/vga_fetch.sv
`timescale 1ns/1ps

module vga_fetch #(
  parameter logic [31:0] VIDMEM   = 32'hc000_0000,
  parameter int          H_ACTIVE = 640,
  parameter int          V_ACTIVE = 480,
  localparam int         RW       = $clog2(V_ACTIVE),
  localparam int         LB_AW    = $clog2(H_ACTIVE / vga_pkg::PIX_PER_WORD)
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  line_start_i,
  input  logic [RW-1:0]         next_row_i,
  output logic [31:0]           master_adr_o,
  output logic                  master_cyc_o,
  input  vga_pkg::bus_word_t    master_dat_i,
  input  logic                  master_ack_i,
  output logic [0:vga_pkg::PIX_PER_WORD-1][vga_pkg::PAL_AW-1:0] pal_idx_o,
  output logic                  store_en_o,
  output logic [LB_AW-1:0]      store_addr_o
);

  import vga_pkg::*;

  localparam int LAST_COL = H_ACTIVE / PIX_PER_WORD - 1;

  fetch_state_e     state;
  logic [LB_AW-1:0] col;
  logic [31:0]      row_base;
  bus_word_t        idx_q;
  logic             col_last;

  assign col_last = (col == LB_AW'(LAST_COL));

  // ##########################################################
  // row fetch FSM
  // ##########################################################

  // one word per pass: bus until ack, then palette read, then store.
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state    <= ST_IDLE;
      col      <= '0;
      row_base <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (line_start_i) begin
            state    <= ST_BUS;
            col      <= '0;
            row_base <= 32'(next_row_i) * 32'(H_ACTIVE);
          end
        end
        ST_BUS: begin
          if (master_ack_i) begin
            state <= ST_PALETTE;
          end
        end
        ST_PALETTE: begin
          state <= ST_STORE;
        end
        ST_STORE: begin
          if (col_last) begin
            state <= ST_IDLE;
          end else begin
            state <= ST_BUS;
            col   <= col + 1'b1;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // index bytes captured with the ack.
  always_ff @(posedge clk_i) begin
    if ((state == ST_BUS) && master_ack_i) begin
      idx_q <= master_dat_i;
    end
  end

  // ##########################################################
  // bus and store side
  // ##########################################################

  // address only moves in store, so it holds through a late ack.
  assign master_adr_o = VIDMEM + row_base + (32'(col) << 2);
  assign master_cyc_o = (state == ST_BUS);

  assign pal_idx_o    = idx_q.quad;
  assign store_en_o   = (state == ST_STORE);
  assign store_addr_o = col;

endmodule

//--- rtl/vga_line_buffer.sv
`timescale 1ns/1ps

module vga_line_buffer #(
  parameter int AW = 8
) (
  input  logic          clk_i,
  input  logic          wr_en_i,
  input  logic [AW-1:0] wr_addr_i,
  input  vga_pkg::rgb_t wr_data_i,
  input  logic [AW-1:0] rd_addr_i,
  output vga_pkg::rgb_t rd_data_o
);

  import vga_pkg::*;

  // one lane, every fourth pixel of the row.
  rgb_t mem [2**AW];

  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      mem[wr_addr_i] <= wr_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    rd_data_o <= mem[rd_addr_i];
  end

endmodule

//--- rtl/vga_master.sv
`timescale 1ns/1ps

module vga_master #(
  parameter logic [31:0] VIDMEM   = 32'hc000_0000,
  parameter int          H_ACTIVE = 640,
  parameter int          H_FRONT  = 16,
  parameter int          H_SYNC   = 96,
  parameter int          H_BACK   = 48,
  parameter int          V_ACTIVE = 480,
  parameter int          V_FRONT  = 10,
  parameter int          V_SYNC   = 2,
  parameter int          V_BACK   = 33
) (
  input  logic                       clk_i,
  input  logic                       rst_i,
  output logic [31:0]                master_adr_o,
  output logic                       master_cyc_o,
  output logic                       master_stb_o,
  output logic                       master_we_o,
  output logic [3:0]                 master_sel_o,
  output logic [31:0]                master_dat_o,
  input  vga_pkg::bus_word_t         master_dat_i,
  input  logic                       master_ack_i,
  input  logic [vga_pkg::PAL_AW-1:0] slave_adr_i,
  input  vga_pkg::bus_word_t         slave_dat_i,
  input  logic                       slave_cyc_i,
  input  logic                       slave_stb_i,
  input  logic                       slave_we_i,
  input  logic [3:0]                 slave_sel_i,
  output logic [31:0]                slave_dat_o,
  output logic                       slave_ack_o,
  output logic                       hs_o,
  output logic                       vs_o,
  output logic                       blank_n_o,
  output logic [7:0]                 r_o,
  output logic [7:0]                 g_o,
  output logic [7:0]                 b_o
);

  import vga_pkg::*;

  localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  localparam int XW      = $clog2(H_TOTAL);
  localparam int RW      = $clog2(V_ACTIVE);
  localparam int LB_AW   = $clog2(H_ACTIVE / PIX_PER_WORD);

  logic                                hs;
  logic                                vs;
  logic                                active;
  logic [XW-1:0]                       x;
  logic                                line_start;
  logic [RW-1:0]                       next_row;
  logic [0:PIX_PER_WORD-1][PAL_AW-1:0] pal_idx;
  logic                                store_en;
  logic [LB_AW-1:0]                    store_addr;
  logic                                pal_wr_en;
  rgb_t                                pal_wr_data;
  rgb_t                                pal_data [PIX_PER_WORD];
  rgb_t                                lb_data [PIX_PER_WORD];
  logic [LB_AW-1:0]                    lb_rd_addr;
  logic [1:0]                          lane_q;
  rgb_t                                pix;

  // ##########################################################
  // Wishbone slave, palette writes
  // ##########################################################

  assign pal_wr_en   = slave_cyc_i && slave_stb_i && slave_we_i && (|slave_sel_i);
  assign pal_wr_data = {slave_dat_i.entry.red, slave_dat_i.entry.green, slave_dat_i.entry.blue};
  assign slave_dat_o = 32'h0;

  // ack for one cycle, then low for one cycle.
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      slave_ack_o <= 1'b0;
    end else begin
      slave_ack_o <= !slave_ack_o && slave_cyc_i && slave_stb_i;
    end
  end

  // ##########################################################
  // timing, fetch and memories
  // ##########################################################

  vga_timing #(
    .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
    .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
  ) u_vga_timing (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .hs_o        (hs),
    .vs_o        (vs),
    .active_o    (active),
    .x_o         (x),
    .y_o         (),
    .line_start_o(line_start),
    .next_row_o  (next_row)
  );

  vga_fetch #(
    .VIDMEM(VIDMEM), .H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)
  ) u_vga_fetch (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .line_start_i(line_start),
    .next_row_i  (next_row),
    .master_adr_o(master_adr_o),
    .master_cyc_o(master_cyc_o),
    .master_dat_i(master_dat_i),
    .master_ack_i(master_ack_i),
    .pal_idx_o   (pal_idx),
    .store_en_o  (store_en),
    .store_addr_o(store_addr)
  );

  assign master_stb_o = master_cyc_o;
  assign master_we_o  = 1'b0;
  assign master_sel_o = 4'hf;
  assign master_dat_o = 32'h0;

  assign lb_rd_addr = LB_AW'(x >> 2);

  // four palette copies feed four interleaved line buffer lanes.
  for (genvar i = 0; i < PIX_PER_WORD; i++) begin : g_lane
    vga_palette u_vga_palette (
      .clk_i    (clk_i),
      .wr_en_i  (pal_wr_en),
      .wr_addr_i(slave_adr_i),
      .wr_data_i(pal_wr_data),
      .rd_addr_i(pal_idx[i]),
      .rd_data_o(pal_data[i])
    );

    vga_line_buffer #(
      .AW(LB_AW)
    ) u_vga_line_buffer (
      .clk_i    (clk_i),
      .wr_en_i  (store_en),
      .wr_addr_i(store_addr),
      .wr_data_i(pal_data[i]),
      .rd_addr_i(lb_rd_addr),
      .rd_data_o(lb_data[i])
    );
  end

  // ##########################################################
  // pixel output
  // ##########################################################

  // syncs and blank follow the one-cycle line buffer read.
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      hs_o      <= 1'b1;
      vs_o      <= 1'b1;
      blank_n_o <= 1'b0;
    end else begin
      hs_o      <= hs;
      vs_o      <= vs;
      blank_n_o <= active;
    end
  end

  always_ff @(posedge clk_i) begin
    lane_q <= x[1:0];
  end

  assign pix = lb_data[lane_q];

  // black outside the visible area.
  assign {r_o, g_o, b_o} = blank_n_o ? pix : '0;

endmodule

//--- rtl/vga_palette.sv
`timescale 1ns/1ps

module vga_palette (
  input  logic                      clk_i,
  input  logic                      wr_en_i,
  input  logic [vga_pkg::PAL_AW-1:0] wr_addr_i,
  input  vga_pkg::rgb_t             wr_data_i,
  input  logic [vga_pkg::PAL_AW-1:0] rd_addr_i,
  output vga_pkg::rgb_t             rd_data_o
);

  import vga_pkg::*;

  rgb_t mem [2**PAL_AW];

  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      mem[wr_addr_i] <= wr_data_i;
    end
  end

  // registered read, colour valid one cycle after the index.
  always_ff @(posedge clk_i) begin
    rd_data_o <= mem[rd_addr_i];
  end

endmodule

//--- rtl/vga_pkg.sv
package vga_pkg;

  // palette address width, one byte per pixel index.
  localparam int PAL_AW = 8;

  // pixels carried by one 32-bit video memory word.
  localparam int PIX_PER_WORD = 4;

  // 24-bit colour with red in the high byte.
  typedef logic [23:0] rgb_t;

  typedef enum logic [1:0] {
    ST_IDLE    = 2'h0,
    ST_BUS     = 2'h1,
    ST_PALETTE = 2'h2,
    ST_STORE   = 2'h3
  } fetch_state_e;

  // palette write word, the top byte is ignored.
  typedef struct packed {
    logic [7:0] unused;
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
  } colour_entry_t;

  // one Wishbone data word.
  // as video memory it holds four indices, quad[0] is the leftmost pixel in bits 31:24.
  // as a palette write it holds one colour entry.
  typedef union packed {
    logic [0:PIX_PER_WORD-1][PAL_AW-1:0] quad;
    colour_entry_t                       entry;
  } bus_word_t;

endpackage

//--- rtl/vga_timing.sv
`timescale 1ns/1ps

module vga_timing #(
  parameter int H_ACTIVE = 640,
  parameter int H_FRONT  = 16,
  parameter int H_SYNC   = 96,
  parameter int H_BACK   = 48,
  parameter int V_ACTIVE = 480,
  parameter int V_FRONT  = 10,
  parameter int V_SYNC   = 2,
  parameter int V_BACK   = 33,
  localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK,
  localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK,
  localparam int XW      = $clog2(H_TOTAL),
  localparam int YW      = $clog2(V_TOTAL),
  localparam int RW      = $clog2(V_ACTIVE)
) (
  input  logic          clk_i,
  input  logic          rst_i,
  output logic          hs_o,
  output logic          vs_o,
  output logic          active_o,
  output logic [XW-1:0] x_o,
  output logic [YW-1:0] y_o,
  output logic          line_start_o,
  output logic [RW-1:0] next_row_o
);

  localparam int HS_START = H_ACTIVE + H_FRONT;
  localparam int HS_END   = HS_START + H_SYNC;
  localparam int VS_START = V_ACTIVE + V_FRONT;
  localparam int VS_END   = VS_START + V_SYNC;

  logic [XW-1:0] x_q;
  logic [YW-1:0] y_q;
  logic          x_last;
  logic          y_last;

  assign x_last = (x_q == XW'(H_TOTAL - 1));
  assign y_last = (y_q == YW'(V_TOTAL - 1));

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      x_q <= '0;
      y_q <= '0;
    end else if (x_last) begin
      x_q <= '0;
      if (y_last) begin
        y_q <= '0;
      end else begin
        y_q <= y_q + 1'b1;
      end
    end else begin
      x_q <= x_q + 1'b1;
    end
  end

  assign x_o = x_q;
  assign y_o = y_q;

  // sync pulses are active low.
  assign hs_o     = !((x_q >= XW'(HS_START)) && (x_q < XW'(HS_END)));
  assign vs_o     = !((y_q >= YW'(VS_START)) && (y_q < YW'(VS_END)));
  assign active_o = (x_q < XW'(H_ACTIVE)) && (y_q < YW'(V_ACTIVE));

  // fetch strobe right after the last active pixel.
  // the last blank line requests row 0 for the coming frame.
  assign line_start_o = (x_q == XW'(H_ACTIVE)) && ((y_q < YW'(V_ACTIVE - 1)) || y_last);
  assign next_row_o   = y_last ? '0 : RW'(y_q + 1'b1);

endmodule

//--- sim.f
rtl/vga_pkg.sv
rtl/vga_timing.sv
rtl/vga_palette.sv
rtl/vga_line_buffer.sv
rtl/vga_fetch.sv
rtl/vga_master.sv
testbench/vga_master_checker.sv
testbench/vga_master_tb.sv

//--- testbench/vga_master_checker.sv
`timescale 1ns/1ps

module vga_master_checker #(
  parameter logic [31:0] VIDMEM   = 32'hc000_0000,
  parameter int          H_ACTIVE = 640,
  parameter int          V_ACTIVE = 480
) (
  input logic                  clk_i,
  input logic                  rst_i,
  input logic [31:0]           master_adr_i,
  input logic                  master_cyc_i,
  input logic                  master_stb_i,
  input logic                  master_ack_i,
  input logic                  slave_ack_i,
  input logic                  hs_i,
  input logic                  vs_i,
  input logic                  blank_n_i,
  input vga_pkg::fetch_state_e fetch_state_i
);

  import vga_pkg::*;

  localparam logic [31:0] FRAME_BYTES = 32'(H_ACTIVE * V_ACTIVE);

  int unsigned error_count = 0;

  // ##########################################################
  // Wishbone master
  // ##########################################################

  stb_matches_cyc: assert property (@(posedge clk_i) disable iff (rst_i)
    master_stb_i == master_cyc_i)
    else begin
      $error("master stb differs from master cyc");
      error_count++;
    end

  adr_word_aligned: assert property (@(posedge clk_i) disable iff (rst_i)
    master_cyc_i |-> (master_adr_i[1:0] == 2'b00))
    else begin
      $error("master address is not word aligned");
      error_count++;
    end

  // unsigned difference also catches addresses below the base.
  adr_in_frame: assert property (@(posedge clk_i) disable iff (rst_i)
    master_cyc_i |-> ((master_adr_i - VIDMEM) < FRAME_BYTES))
    else begin
      $error("master address outside the frame");
      error_count++;
    end

  adr_held_until_ack: assert property (@(posedge clk_i) disable iff (rst_i)
    (master_cyc_i && !master_ack_i) |=> (master_cyc_i && $stable(master_adr_i)))
    else begin
      $error("master cycle or address changed while waiting for ack");
      error_count++;
    end

  // ##########################################################
  // Wishbone slave and reset
  // ##########################################################

  slave_ack_one_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
    slave_ack_i |=> !slave_ack_i)
    else begin
      $error("slave ack high for more than one cycle");
      error_count++;
    end

  reset_state: assert property (@(posedge clk_i)
    rst_i |-> (!master_cyc_i && !slave_ack_i && hs_i && vs_i && !blank_n_i &&
               (fetch_state_i == ST_IDLE)))
    else begin
      $error("outputs or fetch state wrong during reset");
      error_count++;
    end

endmodule

bind vga_master vga_master_checker #(
  .VIDMEM  (VIDMEM),
  .H_ACTIVE(H_ACTIVE),
  .V_ACTIVE(V_ACTIVE)
) u_vga_master_checker (
  .clk_i        (clk_i),
  .rst_i        (rst_i),
  .master_adr_i (master_adr_o),
  .master_cyc_i (master_cyc_o),
  .master_stb_i (master_stb_o),
  .master_ack_i (master_ack_i),
  .slave_ack_i  (slave_ack_o),
  .hs_i         (hs_o),
  .vs_i         (vs_o),
  .blank_n_i    (blank_n_o),
  .fetch_state_i(u_vga_fetch.state)
);

//--- testbench/vga_master_tb.sv
`timescale 1ns/1ps

module vga_master_tb;

  localparam logic [31:0] VIDMEM = 32'h4000_0100;
  localparam int H_ACTIVE = 16;
  localparam int H_FRONT  = 2;
  localparam int H_SYNC   = 2;
  localparam int H_BACK   = 20;
  localparam int V_ACTIVE = 4;
  localparam int V_FRONT  = 1;
  localparam int V_SYNC   = 2 - 1;
  localparam int V_BACK   = 2;
  localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  localparam int WORDS_PER_ROW = H_ACTIVE / 4;
  localparam int VMEM_WORDS    = WORDS_PER_ROW * V_ACTIVE;

  logic        clk_i;
  logic        rst_i;
  logic [31:0] master_adr_o;
  logic        master_cyc_o;
  logic        master_stb_o;
  logic        master_we_o;
  logic [3:0]  master_sel_o;
  logic [31:0] master_dat_o;
  logic [31:0] master_dat_i;
  logic        master_ack_i;
  logic [7:0]  slave_adr_i;
  logic [31:0] slave_dat_i;
  logic        slave_cyc_i;
  logic        slave_stb_i;
  logic        slave_we_i;
  logic [3:0]  slave_sel_i;
  logic [31:0] slave_dat_o;
  logic        slave_ack_o;
  logic        hs_o;
  logic        vs_o;
  logic        blank_n_o;
  logic [7:0]  r_o;
  logic [7:0]  g_o;
  logic [7:0]  b_o;

  logic [31:0] vmem [VMEM_WORDS];
  logic [23:0] pal_model [256];
  logic [7:0]  p_addr [$];
  logic [31:0] p_data [$];
  logic [7:0]  q_addr [$];
  logic [31:0] q_data [$];
  integer      seed;
  int          frames = 0;
  int          vmem_count = 0;
  int          timeout_limit = 0;
  int          cycle_count = 0;
  int          fetch_k = 0;
  int          last_fetched_row = 0;
  int          frames_done = 0;
  int          line_pix = 0;
  int          line_idx = 0;
  int          frame_pix = 0;
  int          hs_low = 0;
  int          vs_low = 0;
  logic        check_en = 1'b0;

  vga_master #(
    .VIDMEM(VIDMEM), .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC),
    .H_BACK(H_BACK), .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC),
    .V_BACK(V_BACK)
  ) u_vga_master (
    .clk_i(clk_i), .rst_i(rst_i),
    .master_adr_o(master_adr_o), .master_cyc_o(master_cyc_o),
    .master_stb_o(master_stb_o), .master_we_o(master_we_o),
    .master_sel_o(master_sel_o), .master_dat_o(master_dat_o),
    .master_dat_i(master_dat_i), .master_ack_i(master_ack_i),
    .slave_adr_i(slave_adr_i), .slave_dat_i(slave_dat_i), .slave_cyc_i(slave_cyc_i),
    .slave_stb_i(slave_stb_i), .slave_we_i(slave_we_i), .slave_sel_i(slave_sel_i),
    .slave_dat_o(slave_dat_o), .slave_ack_o(slave_ack_o),
    .hs_o(hs_o), .vs_o(vs_o), .blank_n_o(blank_n_o), .r_o(r_o), .g_o(g_o), .b_o(b_o)
  );

  always #4 clk_i = ~clk_i;

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      fail_run($sformatf("[FAIL] %s: got %h, expected %h", name, actual, expected));
    end
  endtask

  // colour of pixel (col, row) from the word layout and the palette copy.
  function automatic logic [23:0] expected_colour(input int col, input int row);
    logic [31:0] word;
    logic [7:0]  idx;
    word = vmem[row * WORDS_PER_ROW + col / 4];
    idx  = word[8 * (3 - col % 4) +: 8];
    return pal_model[idx];
  endfunction

  task automatic read_trace();
    int          fd;
    int          code;
    string       text_line;
    logic [7:0]  tag;
    logic [31:0] field_a;
    logic [31:0] field_b;
    fd = $fopen("testbench/vga_trace.txt", "r");
    if (fd == 0) begin
      fail_run("could not open testbench/vga_trace.txt");
    end
    while (!$feof(fd)) begin
      code = $fgets(text_line, fd);
      if (code > 0) begin
        code = $sscanf(text_line, "%c %h %h", tag, field_a, field_b);
        case (tag)
          "P": begin
            p_addr.push_back(field_a[7:0]);
            p_data.push_back(field_b);
          end
          "Q": begin
            q_addr.push_back(field_a[7:0]);
            q_data.push_back(field_b);
          end
          "M": begin
            if (field_a >= VMEM_WORDS) begin
              fail_run("trace word offset lies outside the frame");
            end
            vmem[field_a] = field_b;
            vmem_count++;
          end
          "F": frames = field_a;
          "#", " ", 8'h0a, 8'h0d: ;
          default: fail_run("trace file holds a line with an unknown tag");
        endcase
      end
    end
    $fclose(fd);
  endtask

  // one slave write, ack expected exactly one cycle after cyc and stb.
  task automatic palette_write(input logic [7:0] addr, input logic [31:0] data);
    pal_model[addr] = data[23:0];
    @(negedge clk_i);
    slave_adr_i = addr;
    slave_dat_i = data;
    slave_cyc_i = 1'b1;
    slave_stb_i = 1'b1;
    slave_we_i  = 1'b1;
    check_value("slave_ack_o", slave_ack_o, 1'b0);
    @(negedge clk_i);
    check_value("slave_ack_o", slave_ack_o, 1'b1);
    check_value("slave_dat_o", slave_dat_o, 32'h0);
    slave_cyc_i = 1'b0;
    slave_stb_i = 1'b0;
    slave_we_i  = 1'b0;
    @(negedge clk_i);
    check_value("slave_ack_o", slave_ack_o, 1'b0);
  endtask

  // ##########################################################
  // video memory model
  // ##########################################################

  always begin : memory_model
    int unsigned delay;
    int unsigned word_off;
    @(negedge clk_i);
    master_ack_i = 1'b0;
    if (!rst_i && master_cyc_o && master_stb_o) begin
      check_value("master_we_o", master_we_o, 1'b0);
      check_value("master_sel_o", master_sel_o, 4'hf);
      check_value("master_dat_o", master_dat_o, 32'h0);
      word_off = (master_adr_o - VIDMEM) >> 2;
      if (word_off >= VMEM_WORDS) begin
        fail_run("master address lies outside the frame");
      end
      // words of a row come in order 0..3, rows one after the other.
      check_value("fetch word in row", word_off % WORDS_PER_ROW, fetch_k);
      if (fetch_k == 0) begin
        check_value("fetch row", word_off / WORDS_PER_ROW, (last_fetched_row + 1) % V_ACTIVE);
      end
      if (fetch_k == WORDS_PER_ROW - 1) begin
        last_fetched_row = word_off / WORDS_PER_ROW;
      end
      fetch_k = (fetch_k + 1) % WORDS_PER_ROW;
      delay = $unsigned($random(seed)) % 4;
      repeat (delay) @(negedge clk_i);
      master_dat_i = vmem[word_off];
      master_ack_i = 1'b1;
    end
  end

  // ##########################################################
  // pixel and sync checks
  // ##########################################################

  always @(negedge clk_i) begin : pixel_monitor
    logic [23:0] want;
    logic        hs_fall;
    logic        vs_fall;
    if (!rst_i) begin
      hs_fall = !hs_o && (hs_low == 0);
      vs_fall = !vs_o && (vs_low == 0);
      if (!hs_o) begin
        hs_low++;
      end else if (hs_low != 0) begin
        check_value("hs_o low cycles", hs_low, H_SYNC);
        hs_low = 0;
      end
      if (!vs_o) begin
        vs_low++;
      end else if (vs_low != 0) begin
        check_value("vs_o low cycles", vs_low, V_SYNC * H_TOTAL);
        vs_low = 0;
      end
      if (check_en) begin
        if (blank_n_o && (line_pix >= H_ACTIVE || line_idx >= V_ACTIVE)) begin
          fail_run("blank_n_o high outside the visible area");
        end else if (blank_n_o) begin
          if (line_pix == 0) begin
            check_value("last fetched row", last_fetched_row, line_idx);
          end
          want = expected_colour(line_pix, line_idx);
          check_value("r_o", r_o, want[23:16]);
          check_value("g_o", g_o, want[15:8]);
          check_value("b_o", b_o, want[7:0]);
          line_pix++;
          frame_pix++;
        end else begin
          check_value("{r_o,g_o,b_o} in blank", {r_o, g_o, b_o}, 24'h0);
        end
        if (hs_fall && line_pix != 0) begin
          check_value("active pixels per line", line_pix, H_ACTIVE);
          line_idx++;
          line_pix = 0;
        end
        if (vs_fall) begin
          check_value("active pixels per frame", frame_pix, V_ACTIVE * H_ACTIVE);
          check_value("active lines per frame", line_idx, V_ACTIVE);
          frames_done++;
          frame_pix = 0;
          line_idx  = 0;
        end
      end else if (vs_fall) begin
        // the frame after reset starts without row 0 in the line store.
        check_en = 1'b1;
      end
    end
  end

  always @(negedge clk_i) begin
    if (u_vga_master.u_vga_master_checker.error_count != 0) begin
      fail_run("a bus or reset assertion in the checker failed");
    end
  end

  always @(posedge clk_i) begin
    cycle_count++;
    if (timeout_limit != 0 && cycle_count > timeout_limit) begin
      fail_run($sformatf("timeout after %0d cycles, %0d of %0d frames checked",
                         cycle_count, frames_done, frames));
    end
  end

  initial begin : main
    clk_i        = 1'b0;
    rst_i        = 1'b1;
    master_dat_i = 32'h0;
    master_ack_i = 1'b0;
    slave_adr_i  = 8'h0;
    slave_dat_i  = 32'h0;
    slave_cyc_i  = 1'b0;
    slave_stb_i  = 1'b0;
    slave_we_i   = 1'b0;
    slave_sel_i  = 4'hf;
    seed         = 32'h5df7_3e69;
    read_trace();
    if (vmem_count != VMEM_WORDS || frames < 2) begin
      fail_run("trace needs every video memory word and at least two frames");
    end
    timeout_limit = frames * 30 * H_TOTAL + 200;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    foreach (p_addr[i]) begin
      palette_write(p_addr[i], p_data[i]);
    end
    // rewrite in the vertical blank after the first checked frame.
    wait (frames_done >= 1);
    foreach (q_addr[i]) begin
      palette_write(q_addr[i], q_data[i]);
    end
    wait (frames_done >= frames);
    if (u_vga_master.u_vga_master_checker.error_count == 0) begin
      $display("Testbench passed");
      $finish;
    end else begin
      fail_run("checker assertions failed during the run");
    end
  end

endmodule

//--- testbench/vga_trace.txt
# P and Q: palette index, colour word (top byte ignored); Q lines apply after the first frame
# M: video memory word offset, data with the leftmost pixel in the top byte; F: frames to check
P 00 00000000
P 01 00ff0000
P 02 0000ff00
P 03 000000ff
P 10 00ffffff
P 11 00808080
P 20 a5123456
P 33 5a00c0ff
P 7f 007f7f00
P 80 0000ffff
P c5 00ff00ff
P ff 00102030
M 0 00010203
M 1 10112033
M 2 7f80c5ff
M 3 03020100
M 4 ff0110c5
M 5 2033807f
M 6 11000302
M 7 c5ff2010
M 8 33331111
M 9 01020301
M a 80807f7f
M b ff00ff00
M c 10203380
M d c57f1102
M e 03ff0001
M f 20101033
Q 01 00aa55aa
Q 10 ff010203
Q 80 00446688
Q ff 00e0e0e0
F 3
